// File: hw/riscv_isa_pkg.sv
// RV32I subset encodings, instruction field layout and ALU operation codes for all stages
`default_nettype none

package riscv_isa_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////////////////////////////////////////////////////
  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // funct3 codes
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  localparam logic [6:0] F7_SUB = 7'b0100000;  // SUB variant of ADD

  localparam logic [31:0] NOP_INSN = 32'h0000_0013;  // ADDI x0,x0,0

  // R-type view, other formats decoded from raw bits
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } insn_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

endpackage

`default_nettype wire

// File: hw/riscv_pipe_pkg.sv
// Stage payload records passed between fetch, decode, execute and the retire port
`default_nettype none

package riscv_pipe_pkg;

  localparam logic [riscv_isa_pkg::XLEN-1:0] RESET_PC   = '0;
  localparam logic [riscv_isa_pkg::XLEN-1:0] INSN_BYTES = 4;  // No compressed parcels

  typedef enum logic [1:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_JAL
  } branch_e;

  typedef struct packed {
    logic [riscv_isa_pkg::XLEN-1:0] pc;
    logic [31:0]                    insn;
  } fetch_t;

  typedef struct packed {
    logic [riscv_isa_pkg::XLEN-1:0] pc;
    riscv_isa_pkg::reg_addr_t       rd;
    logic                           we;     // Real write, never x0
    riscv_isa_pkg::alu_op_e         alu_op;
    logic [riscv_isa_pkg::XLEN-1:0] op_a;
    logic [riscv_isa_pkg::XLEN-1:0] op_b;
    branch_e                        br;
    logic [riscv_isa_pkg::XLEN-1:0] cmp_a;  // Branch compare operands
    logic [riscv_isa_pkg::XLEN-1:0] cmp_b;
    logic [riscv_isa_pkg::XLEN-1:0] imm;    // Target offset
  } decode_t;

  typedef struct packed {
    logic [riscv_isa_pkg::XLEN-1:0] pc;
    riscv_isa_pkg::reg_addr_t       rd;
    logic                           we;
    logic [riscv_isa_pkg::XLEN-1:0] value;
  } retire_t;

endpackage

`default_nettype wire

// File: hw/riscv_pipe_reg.sv
// One-entry valid/ready register placed on each stage boundary, flushable on redirect
`default_nettype none

module riscv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     flush_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Accept when empty or when drained this cycle
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;  // Flush beats a load
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// File: hw/riscv_if.sv
// Fetch stage owning the PC, one outstanding imem request and a one-entry response buffer
`default_nettype none

module riscv_if (
  input  logic                           clk_i,
  input  logic                           reset_i,
  output logic                           imem_req_valid_o,
  input  logic                           imem_req_ready_i,
  output logic [riscv_isa_pkg::XLEN-1:0] imem_req_addr_o,
  input  logic                           imem_rsp_valid_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] imem_rsp_data_i,
  input  logic                           redirect_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] redirect_pc_i,
  output logic                           fetch_valid_o,
  input  logic                           fetch_ready_i,
  output riscv_pipe_pkg::fetch_t         fetch_o
);

  logic [riscv_isa_pkg::XLEN-1:0] pc_q;
  logic [riscv_isa_pkg::XLEN-1:0] tgt_q;  // Redirect waiting on a stale response
  logic                           run_q;
  logic                           out_q;
  logic                           stale_q;
  logic                           buf_q;
  riscv_pipe_pkg::fetch_t         buf_data_q;
  logic                           rsp_take;
  logic                           rsp_live;
  logic                           pend;

  // Next request only once the previous response has left fetch
  assign imem_req_valid_o = run_q && !out_q && !buf_q;
  assign imem_req_addr_o  = pc_q;

  assign rsp_take = out_q && imem_rsp_valid_i;
  assign rsp_live = rsp_take && !stale_q;
  assign pend     = imem_req_valid_o || (out_q && !imem_rsp_valid_i);  // Addr must hold

  assign fetch_valid_o = buf_q || rsp_live;
  assign fetch_o = buf_q ? buf_data_q
                         : riscv_pipe_pkg::fetch_t'{pc: pc_q, insn: imem_rsp_data_i};

  //////////////////////////////////////////////////////////////////////////////
  // Request, response and redirect tracking
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      run_q   <= 1'b0;
      out_q   <= 1'b0;
      stale_q <= 1'b0;
      buf_q   <= 1'b0;
      pc_q    <= riscv_pipe_pkg::RESET_PC;
    end else begin
      run_q <= 1'b1;
      if (imem_req_valid_o && imem_req_ready_i) begin
        out_q <= 1'b1;
      end else if (rsp_take) begin
        out_q <= 1'b0;
      end
      if (rsp_live) begin
        pc_q <= pc_q + riscv_pipe_pkg::INSN_BYTES;
      end
      if (rsp_take && stale_q) begin  // Drop it and go to the target
        stale_q <= 1'b0;
        pc_q    <= tgt_q;
      end
      if (rsp_live && !fetch_ready_i) begin
        buf_q <= 1'b1;
      end else if (fetch_ready_i) begin
        buf_q <= 1'b0;
      end
      if (redirect_i) begin
        if (pend) begin
          stale_q <= 1'b1;
        end else begin
          pc_q  <= redirect_pc_i;
          buf_q <= 1'b0;  // Wrong-path item
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_live && !fetch_ready_i) begin
      buf_data_q <= fetch_o;
    end
    if (redirect_i) begin
      tgt_q <= redirect_pc_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/riscv_rf.sv
// Integer register file, combinational reads and one write port at the retire edge
`default_nettype none

module riscv_rf (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  riscv_isa_pkg::reg_addr_t       rs1_i,
  input  riscv_isa_pkg::reg_addr_t       rs2_i,
  output logic [riscv_isa_pkg::XLEN-1:0] rs1_q_o,
  output logic [riscv_isa_pkg::XLEN-1:0] rs2_q_o,
  input  logic                           we_i,
  input  riscv_isa_pkg::reg_addr_t       rd_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] rd_d_i
);

  localparam int NREGS = 2 ** riscv_isa_pkg::REG_ADDR_W;

  logic [riscv_isa_pkg::XLEN-1:0] regs_q [NREGS];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin  // x0 stays zero
      regs_q[rd_i] <= rd_d_i;
    end
  end

  assign rs1_q_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
  assign rs2_q_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

`default_nettype wire

// File: hw/riscv_id.sv
// Decode stage with immediate generation and EX/WB operand bypass ahead of the ID/EX register
`default_nettype none

module riscv_id (
  input  riscv_pipe_pkg::fetch_t         fetch_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] rs1_q_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] rs2_q_i,
  output riscv_isa_pkg::reg_addr_t       rs1_o,
  output riscv_isa_pkg::reg_addr_t       rs2_o,
  input  riscv_pipe_pkg::retire_t        ex_fwd_i,
  input  riscv_pipe_pkg::retire_t        wb_fwd_i,
  input  logic                           ex_fwd_valid_i,
  input  logic                           wb_fwd_valid_i,
  output riscv_pipe_pkg::decode_t        decode_o
);

  riscv_isa_pkg::insn_t           raw;
  riscv_isa_pkg::insn_t           ins;
  logic                           legal;
  logic                           wr;
  logic [riscv_isa_pkg::XLEN-1:0] imm_i;
  logic [riscv_isa_pkg::XLEN-1:0] imm_b;
  logic [riscv_isa_pkg::XLEN-1:0] imm_u;
  logic [riscv_isa_pkg::XLEN-1:0] imm_j;
  logic [riscv_isa_pkg::XLEN-1:0] rs1_val;
  logic [riscv_isa_pkg::XLEN-1:0] rs2_val;

  function automatic riscv_isa_pkg::alu_op_e alu_of(input logic [2:0] f3, input logic sub);
    case (f3)
      riscv_isa_pkg::F3_SLT: return riscv_isa_pkg::ALU_SLT;
      riscv_isa_pkg::F3_XOR: return riscv_isa_pkg::ALU_XOR;
      riscv_isa_pkg::F3_OR:  return riscv_isa_pkg::ALU_OR;
      riscv_isa_pkg::F3_AND: return riscv_isa_pkg::ALU_AND;
      default:               return sub ? riscv_isa_pkg::ALU_SUB : riscv_isa_pkg::ALU_ADD;
    endcase
  endfunction

  assign raw = riscv_isa_pkg::insn_t'(fetch_i.insn);

  //////////////////////////////////////////////////////////////////////////////
  // Unknown encodings become a NOP that still retires
  always_comb begin
    case (raw.opcode)
      riscv_isa_pkg::OPC_OP:
        legal = (raw.funct3 inside {riscv_isa_pkg::F3_ADD, riscv_isa_pkg::F3_SLT,
                                    riscv_isa_pkg::F3_XOR, riscv_isa_pkg::F3_OR,
                                    riscv_isa_pkg::F3_AND} && raw.funct7 == '0) ||
                (raw.funct3 == riscv_isa_pkg::F3_ADD && raw.funct7 == riscv_isa_pkg::F7_SUB);
      riscv_isa_pkg::OPC_OP_IMM:
        legal = raw.funct3 inside {riscv_isa_pkg::F3_ADD, riscv_isa_pkg::F3_XOR,
                                   riscv_isa_pkg::F3_OR, riscv_isa_pkg::F3_AND};
      riscv_isa_pkg::OPC_BRANCH:
        legal = raw.funct3 inside {riscv_isa_pkg::F3_BEQ, riscv_isa_pkg::F3_BNE};
      riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_JAL:
        legal = 1'b1;
      default:
        legal = 1'b0;
    endcase
  end

  assign ins = legal ? raw : riscv_isa_pkg::insn_t'(riscv_isa_pkg::NOP_INSN);

  assign imm_i = {{20{ins[31]}}, ins[31:20]};
  assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  assign imm_u = {ins[31:12], 12'b0};
  assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

  assign rs1_o = ins.rs1;
  assign rs2_o = ins.rs2;

  // Youngest producer wins; we is never set for x0
  assign rs1_val = (ex_fwd_valid_i && ex_fwd_i.we && ex_fwd_i.rd == ins.rs1) ? ex_fwd_i.value :
                   (wb_fwd_valid_i && wb_fwd_i.we && wb_fwd_i.rd == ins.rs1) ? wb_fwd_i.value :
                   rs1_q_i;
  assign rs2_val = (ex_fwd_valid_i && ex_fwd_i.we && ex_fwd_i.rd == ins.rs2) ? ex_fwd_i.value :
                   (wb_fwd_valid_i && wb_fwd_i.we && wb_fwd_i.rd == ins.rs2) ? wb_fwd_i.value :
                   rs2_q_i;

  always_comb begin
    wr              = 1'b1;
    decode_o.pc     = fetch_i.pc;
    decode_o.rd     = ins.rd;
    decode_o.alu_op = alu_of(ins.funct3, 1'b0);
    decode_o.op_a   = rs1_val;
    decode_o.op_b   = imm_i;
    decode_o.br     = riscv_pipe_pkg::BR_NONE;
    decode_o.cmp_a  = rs1_val;
    decode_o.cmp_b  = rs2_val;
    decode_o.imm    = imm_i;
    case (ins.opcode)
      riscv_isa_pkg::OPC_OP: begin
        decode_o.op_b   = rs2_val;
        decode_o.alu_op = alu_of(ins.funct3, ins.funct7 == riscv_isa_pkg::F7_SUB);
      end
      riscv_isa_pkg::OPC_LUI: begin
        decode_o.alu_op = riscv_isa_pkg::ALU_PASS_B;
        decode_o.op_b   = imm_u;
      end
      riscv_isa_pkg::OPC_BRANCH: begin
        wr           = 1'b0;
        decode_o.imm = imm_b;
        decode_o.br  = (ins.funct3 == riscv_isa_pkg::F3_BNE) ? riscv_pipe_pkg::BR_BNE
                                                             : riscv_pipe_pkg::BR_BEQ;
      end
      riscv_isa_pkg::OPC_JAL: begin  // rd gets the return address
        decode_o.alu_op = riscv_isa_pkg::ALU_ADD;
        decode_o.op_a   = fetch_i.pc;
        decode_o.op_b   = riscv_pipe_pkg::INSN_BYTES;
        decode_o.br     = riscv_pipe_pkg::BR_JAL;
        decode_o.imm    = imm_j;
      end
      default: ;  // OP_IMM defaults
    endcase
    decode_o.we = wr && ins.rd != '0;
  end

endmodule

`default_nettype wire

// File: hw/riscv_ex.sv
// Execute stage that computes the ALU result, branch condition and redirect target from ID/EX
`default_nettype none

module riscv_ex (
  input  riscv_pipe_pkg::decode_t        decode_i,
  output riscv_pipe_pkg::retire_t        result_o,
  output logic                           redirect_o,
  output logic [riscv_isa_pkg::XLEN-1:0] redirect_pc_o
);

  logic [riscv_isa_pkg::XLEN-1:0] alu_r;
  logic                           taken;
  logic                           lt;

  assign lt = $signed(decode_i.op_a) < $signed(decode_i.op_b);

  always_comb begin
    case (decode_i.alu_op)
      riscv_isa_pkg::ALU_ADD: alu_r = decode_i.op_a + decode_i.op_b;
      riscv_isa_pkg::ALU_SUB: alu_r = decode_i.op_a - decode_i.op_b;
      riscv_isa_pkg::ALU_AND: alu_r = decode_i.op_a & decode_i.op_b;
      riscv_isa_pkg::ALU_OR:  alu_r = decode_i.op_a | decode_i.op_b;
      riscv_isa_pkg::ALU_XOR: alu_r = decode_i.op_a ^ decode_i.op_b;
      riscv_isa_pkg::ALU_SLT: alu_r = {{(riscv_isa_pkg::XLEN-1){1'b0}}, lt};
      default:                alu_r = decode_i.op_b;  // LUI
    endcase
  end

  //////////////////////////////////////////////////////////////////////////////
  // Branch resolution
  always_comb begin
    case (decode_i.br)
      riscv_pipe_pkg::BR_BEQ: taken = decode_i.cmp_a == decode_i.cmp_b;
      riscv_pipe_pkg::BR_BNE: taken = decode_i.cmp_a != decode_i.cmp_b;
      riscv_pipe_pkg::BR_JAL: taken = 1'b1;
      default:                taken = 1'b0;
    endcase
  end

  // Core qualifies this with the EX/WB transfer
  assign redirect_o    = taken;
  assign redirect_pc_o = decode_i.pc + decode_i.imm;

  assign result_o = '{pc: decode_i.pc, rd: decode_i.rd, we: decode_i.we, value: alu_r};

endmodule

`default_nettype wire

// File: hw/riscv_core.sv
// Core top level joining fetch, decode, execute and retire through valid/ready stage registers
`default_nettype none

module riscv_core (
  input  logic                           clk_i,
  input  logic                           reset_i,
  output logic                           imem_req_valid_o,
  input  logic                           imem_req_ready_i,
  output logic [riscv_isa_pkg::XLEN-1:0] imem_req_addr_o,
  input  logic                           imem_rsp_valid_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] imem_rsp_data_i,
  output logic                           ret_valid_o,
  input  logic                           ret_ready_i,
  output riscv_pipe_pkg::retire_t        ret_o
);

  riscv_pipe_pkg::fetch_t         if_fetch;
  riscv_pipe_pkg::fetch_t         id_fetch;
  riscv_pipe_pkg::decode_t        id_dec;
  riscv_pipe_pkg::decode_t        ex_dec;
  riscv_pipe_pkg::retire_t        ex_res;
  logic                           if_valid;
  logic                           if_ready;
  logic                           id_valid;
  logic                           id_ready;
  logic                           ex_valid;
  logic                           ex_ready;
  logic                           ex_redirect;
  logic                           redirect;
  logic [riscv_isa_pkg::XLEN-1:0] redirect_pc;
  riscv_isa_pkg::reg_addr_t       rs1;
  riscv_isa_pkg::reg_addr_t       rs2;
  logic [riscv_isa_pkg::XLEN-1:0] rs1_q;
  logic [riscv_isa_pkg::XLEN-1:0] rs2_q;

  // Only a branch that actually moves on to WB redirects
  assign redirect = ex_redirect && ex_valid && ex_ready;

  //////////////////////////////////////////////////////////////////////////////
  // Fetch
  riscv_if if_unit (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .imem_req_valid_o (imem_req_valid_o),
    .imem_req_ready_i (imem_req_ready_i),
    .imem_req_addr_o  (imem_req_addr_o),
    .imem_rsp_valid_i (imem_rsp_valid_i),
    .imem_rsp_data_i  (imem_rsp_data_i),
    .redirect_i       (redirect),
    .redirect_pc_i    (redirect_pc),
    .fetch_valid_o    (if_valid),
    .fetch_ready_i    (if_ready),
    .fetch_o          (if_fetch)
  );

  riscv_pipe_reg #(.payload_t(riscv_pipe_pkg::fetch_t)) if_id_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .flush_i (redirect),
    .valid_i (if_valid),
    .ready_o (if_ready),
    .data_i  (if_fetch),
    .valid_o (id_valid),
    .ready_i (id_ready),
    .data_o  (id_fetch)
  );

  //////////////////////////////////////////////////////////////////////////////
  // Decode and register file
  riscv_rf int_rf (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .rs1_i   (rs1),
    .rs2_i   (rs2),
    .rs1_q_o (rs1_q),
    .rs2_q_o (rs2_q),
    .we_i    (ret_valid_o && ret_ready_i && ret_o.we),  // Write on retire
    .rd_i    (ret_o.rd),
    .rd_d_i  (ret_o.value)
  );

  riscv_id id_unit (
    .fetch_i        (id_fetch),
    .rs1_q_i        (rs1_q),
    .rs2_q_i        (rs2_q),
    .rs1_o          (rs1),
    .rs2_o          (rs2),
    .ex_fwd_i       (ex_res),
    .wb_fwd_i       (ret_o),
    .ex_fwd_valid_i (ex_valid),
    .wb_fwd_valid_i (ret_valid_o),
    .decode_o       (id_dec)
  );

  riscv_pipe_reg #(.payload_t(riscv_pipe_pkg::decode_t)) id_ex_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .flush_i (redirect),
    .valid_i (id_valid),
    .ready_o (id_ready),
    .data_i  (id_dec),
    .valid_o (ex_valid),
    .ready_i (ex_ready),
    .data_o  (ex_dec)
  );

  //////////////////////////////////////////////////////////////////////////////
  // Execute and retire
  riscv_ex ex_unit (
    .decode_i      (ex_dec),
    .result_o      (ex_res),
    .redirect_o    (ex_redirect),
    .redirect_pc_o (redirect_pc)
  );

  riscv_pipe_reg #(.payload_t(riscv_pipe_pkg::retire_t)) ex_wb_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .flush_i (1'b0),  // Older than any redirect
    .valid_i (ex_valid),
    .ready_o (ex_ready),
    .data_i  (ex_res),
    .valid_o (ret_valid_o),
    .ready_i (ret_ready_i),
    .data_o  (ret_o)
  );

endmodule

`default_nettype wire

// File: verif/riscv_core_tb_model.svh
// Random program generator and instruction-level reference model that the core testbench includes
`ifndef RISCV_CORE_TB_MODEL_SVH
`define RISCV_CORE_TB_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Fibonacci LFSR with taps at x^16 + x^14 + x^13 + x^11 + 1
function automatic logic next_bit();
  logic fb;
  fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
  lfsr_q = {lfsr_q[14:0], fb};
  return fb;
endfunction

function automatic int unsigned rand_bits(input int n);
  int unsigned v;
  v = 0;
  for (int k = 0; k < n; k++) begin
    v = (v << 1) | int'(next_bit());
  end
  return v;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
  return {f7, rs2, rs1, f3, rd, riscv_isa_pkg::OPC_OP};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], riscv_isa_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, riscv_isa_pkg::OPC_JAL};
endfunction

// Mostly x0..x7 so that back-to-back dependencies are common
function automatic void gen_program();
  int unsigned kind;
  int unsigned sel;
  int unsigned words;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  for (int i = 0; i < PROG_WORDS - 1; i++) begin
    kind  = rand_bits(4);
    sel   = rand_bits(3);
    rd    = 5'(rand_bits(3));
    rs1   = 5'(rand_bits(3));
    rs2   = 5'(rand_bits(2));
    words = rand_bits(3) + 1;  // Forward only
    if (i + words > PROG_WORDS - 1) begin
      words = PROG_WORDS - 1 - i;
    end
    if (kind < 4) begin
      case (sel)
        0: prog[i] = enc_r(7'b0, 3'b000, rd, rs1, rs2);
        1: prog[i] = enc_r(7'b0100000, 3'b000, rd, rs1, rs2);
        2: prog[i] = enc_r(7'b0, 3'b010, rd, rs1, rs2);
        3: prog[i] = enc_r(7'b0, 3'b100, rd, rs1, rs2);
        4: prog[i] = enc_r(7'b0, 3'b110, rd, rs1, rs2);
        5: prog[i] = enc_r(7'b0, 3'b111, rd, rs1, rs2);
        default: prog[i] = enc_r(7'b0000001, 3'b000, rd, rs1, rs2);  // MUL is not kept
      endcase
    end else if (kind < 8) begin
      // ADDI, XORI, ORI or ANDI
      prog[i] = {12'(rand_bits(12)), rs1, {sel[1:0] != 0, sel[1], sel[1:0] == 2'd3}, rd,
                 riscv_isa_pkg::OPC_OP_IMM};
    end else if (kind < 10) begin
      prog[i] = {20'(rand_bits(20)), rd, riscv_isa_pkg::OPC_LUI};
    end else if (kind < 12) begin
      prog[i] = enc_b(3'b000, {3'b0, rs1[1:0]}, rs2, 13'(words * 4));
    end else if (kind == 12) begin
      prog[i] = enc_b(3'b001, {3'b0, rs1[1:0]}, rs2, 13'(words * 4));
    end else if (kind == 13) begin
      prog[i] = enc_j(rd, 21'(words * 4));
    end else if (kind == 14) begin
      prog[i] = {25'(rand_bits(25)), 7'b0000000};  // Illegal opcode
    end else begin
      prog[i] = {12'h005, rs1, 3'b010, rd, riscv_isa_pkg::OPC_OP_IMM};  // SLTI is not kept
    end
  end
  prog[PROG_WORDS-1] = enc_j(5'd0, 21'd0);  // Self-loop at the end
endfunction

`endif

// File: verif/riscv_core_tb.sv
// Self-checking testbench for riscv_core with a random imem responder and retire back-pressure
`default_nettype none

module riscv_core_tb;

  localparam int NUM_RETIRES = 300;
  localparam int CYCLE_LIMIT = NUM_RETIRES * (3 + 3) * 4 + 800;
  localparam int PROG_WORDS  = 256;

  logic                    clk_i;
  logic                    reset_i;
  logic                    imem_req_valid_o;
  logic                    imem_req_ready_i;
  logic [31:0]             imem_req_addr_o;
  logic                    imem_rsp_valid_i;
  logic [31:0]             imem_rsp_data_i;
  logic                    ret_valid_o;
  logic                    ret_ready_i;
  riscv_pipe_pkg::retire_t ret_o;

  logic [31:0] prog [PROG_WORDS];
  logic [15:0] lfsr_q;
  logic [31:0] mdl_rf [32];
  logic [31:0] mdl_pc;
  logic [31:0] mdl_next;
  logic [31:0] exp_pc;
  logic        exp_we;
  logic [4:0]  exp_rd;
  logic [31:0] exp_val;
  logic        first_req;
  logic        rsp_busy;
  int          rsp_wait;
  logic [31:0] rsp_addr;
  int          cycles;
  int          retired;
  int          value_errors;
  int          protocol_errors;
  int          other_errors;
  logic        ret_fire;

  `include "riscv_core_tb_model.svh"

  // Expected retire record for the instruction at mdl_pc
  function automatic void predict();
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] res;
    logic        wr;
    w     = prog[mdl_pc[9:2]];
    a     = mdl_rf[w[19:15]];
    b     = mdl_rf[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    res   = '0;
    wr    = 1'b0;
    mdl_next = mdl_pc + 4;
    case (w[6:0])
      riscv_isa_pkg::OPC_OP: begin
        wr = 1'b1;
        case ({w[31:25], w[14:12]})
          {7'b0, 3'b000}:         res = a + b;
          {7'b0100000, 3'b000}:   res = a - b;
          {7'b0, 3'b010}:         res = {31'b0, $signed(a) < $signed(b)};
          {7'b0, 3'b100}:         res = a ^ b;
          {7'b0, 3'b110}:         res = a | b;
          {7'b0, 3'b111}:         res = a & b;
          default:                wr = 1'b0;
        endcase
      end
      riscv_isa_pkg::OPC_OP_IMM: begin
        wr = 1'b1;
        case (w[14:12])
          3'b000:  res = a + imm_i;
          3'b100:  res = a ^ imm_i;
          3'b110:  res = a | imm_i;
          3'b111:  res = a & imm_i;
          default: wr = 1'b0;
        endcase
      end
      riscv_isa_pkg::OPC_LUI: begin
        wr  = 1'b1;
        res = {w[31:12], 12'b0};
      end
      riscv_isa_pkg::OPC_BRANCH: begin
        if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b)) begin
          mdl_next = mdl_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      riscv_isa_pkg::OPC_JAL: begin
        wr       = 1'b1;
        res      = mdl_pc + 4;  // Return address
        mdl_next = mdl_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      default: ;
    endcase
    exp_pc  = mdl_pc;
    exp_we  = wr && w[11:7] != 5'd0;
    exp_rd  = w[11:7];
    exp_val = res;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  riscv_core dut (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .imem_req_valid_o (imem_req_valid_o),
    .imem_req_ready_i (imem_req_ready_i),
    .imem_req_addr_o  (imem_req_addr_o),
    .imem_rsp_valid_i (imem_rsp_valid_i),
    .imem_rsp_data_i  (imem_rsp_data_i),
    .ret_valid_o      (ret_valid_o),
    .ret_ready_i      (ret_ready_i),
    .ret_o            (ret_o)
  );

  assign ret_fire = ret_valid_o && ret_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Checks on every retire transfer and on the handshakes
  assert property (@(posedge clk_i) disable iff (reset_i) ret_fire |-> ret_o.pc == exp_pc)
    else begin
      value_errors++;
      $display("ERROR ret_o.pc got %h expected %h", $sampled(ret_o.pc), $sampled(exp_pc));
    end
  assert property (@(posedge clk_i) disable iff (reset_i) ret_fire |-> ret_o.we == exp_we)
    else begin
      value_errors++;
      $display("ERROR ret_o.we got %h expected %h", $sampled(ret_o.we), $sampled(exp_we));
    end
  assert property (@(posedge clk_i) disable iff (reset_i)
                   ret_fire && exp_we |-> ret_o.rd == exp_rd && ret_o.value == exp_val)
    else begin
      value_errors++;
      $display("ERROR ret_o.rd/value got %h/%h expected %h/%h", $sampled(ret_o.rd),
               $sampled(ret_o.value), $sampled(exp_rd), $sampled(exp_val));
    end
  assert property (@(posedge clk_i) disable iff (reset_i)
                   ret_valid_o && !ret_ready_i |=> ret_valid_o && $stable(ret_o))
    else begin
      protocol_errors++;
      $display("Retire record changed while the retire port was stalled");
    end
  assert property (@(posedge clk_i) disable iff (reset_i)
                   imem_req_valid_o && !imem_req_ready_i |=>
                   imem_req_valid_o && $stable(imem_req_addr_o))
    else begin
      protocol_errors++;
      $display("Fetch request dropped or its address moved before ready");
    end
  assert property (@(posedge clk_i) disable iff (reset_i)
                   first_req && imem_req_valid_o |-> imem_req_addr_o == riscv_pipe_pkg::RESET_PC)
    else begin
      value_errors++;
      $display("ERROR imem_req_addr_o got %h expected %h", $sampled(imem_req_addr_o),
               riscv_pipe_pkg::RESET_PC);
    end

  // Model steps once per retire transfer
  always @(posedge clk_i) begin
    if (!reset_i && imem_req_valid_o && imem_req_ready_i) begin
      first_req = 1'b0;
    end
    if (!reset_i && ret_fire) begin
      if (exp_we) begin
        mdl_rf[exp_rd] = exp_val;
      end
      mdl_pc = mdl_next;
      retired++;
      predict();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reset, memory responder and retire back-pressure, all on the falling edge
  always @(negedge clk_i) begin
    cycles++;
    if (cycles == 4) begin
      assert (!ret_valid_o && !imem_req_valid_o)
        else begin
          protocol_errors++;
          $display("Valid outputs are not low after reset");
        end
    end
    reset_i          = cycles < 4;
    imem_rsp_valid_i = 1'b0;
    if (reset_i) begin
      imem_req_ready_i = 1'b0;
      ret_ready_i      = 1'b0;
      rsp_busy         = 1'b0;
    end else begin
      if (rsp_busy) begin
        if (rsp_wait == 1) begin
          imem_rsp_valid_i = 1'b1;
          imem_rsp_data_i  = prog[rsp_addr[9:2]];
          rsp_busy         = 1'b0;
        end else begin
          rsp_wait--;
        end
      end
      imem_req_ready_i = rand_bits(2) != 0;
      if (imem_req_valid_o && imem_req_ready_i) begin
        rsp_busy = 1'b1;
        rsp_addr = imem_req_addr_o;
        rsp_wait = int'(rand_bits(2) % 3) + 1;  // 1 to 3 cycles
      end
      ret_ready_i = rand_bits(2) != 0;
    end
  end

  initial begin
    reset_i          = 1'b1;
    imem_req_ready_i = 1'b0;
    imem_rsp_valid_i = 1'b0;
    imem_rsp_data_i  = '0;
    ret_ready_i      = 1'b0;
    lfsr_q           = 16'd14;
    first_req        = 1'b1;
    rsp_busy         = 1'b0;
    rsp_wait         = 0;
    rsp_addr         = '0;
    cycles           = 0;
    retired          = 0;
    value_errors     = 0;
    protocol_errors  = 0;
    other_errors     = 0;
    for (int r = 0; r < 32; r++) begin
      mdl_rf[r] = '0;
    end
    gen_program();
    mdl_pc = riscv_pipe_pkg::RESET_PC;
    predict();
    wait (retired >= NUM_RETIRES || cycles >= CYCLE_LIMIT);
    if (retired < NUM_RETIRES) begin
      other_errors++;
      $display("Timeout with %0d of %0d retires after %0d cycles", retired, NUM_RETIRES,
               cycles);
    end
    @(negedge clk_i);
    $display("Errors: value %0d, protocol %0d, other %0d", value_errors, protocol_errors,
             other_errors);
    if (value_errors + protocol_errors + other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: riscv_core.f
+incdir+verif
hw/riscv_isa_pkg.sv
hw/riscv_pipe_pkg.sv
hw/riscv_pipe_reg.sv
hw/riscv_if.sv
hw/riscv_rf.sv
hw/riscv_id.sv
hw/riscv_ex.sv
hw/riscv_core.sv
verif/riscv_core_tb.sv

// File: Makefile
# Verilator build and run of the riscv_core testbench

TOP := riscv_core_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f riscv_core.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
